//--- common/spi_pkg.sv
// ------------------------------------------------
// SPI master shared types and constants
// ------------------------------------------------
package spi_pkg;

  // Bus and character widths
  localparam int apb_addr_w = 5;
  localparam int apb_data_w = 32;
  localparam int reg_data_w = 16;
  localparam int reg_addr_w = 3;
  localparam int spi_data_w = 8;
  localparam int ss_w       = 4;

  typedef logic [spi_data_w-1:0] spi_data_t;
  typedef logic [reg_data_w-1:0] reg_data_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [ss_w-1:0]       ss_sel_t;

  // Word addresses, 4 and 7 are reserved
  localparam reg_addr_t addr_rxdata    = 3'd0;
  localparam reg_addr_t addr_txdata    = 3'd1;
  localparam reg_addr_t addr_status    = 3'd2;
  localparam reg_addr_t addr_control   = 3'd3;
  localparam reg_addr_t addr_slave_sel = 3'd5;
  localparam reg_addr_t addr_eop_value = 3'd6;

  // Status and control bit positions
  localparam int bit_roe  = 3;
  localparam int bit_toe  = 4;
  localparam int bit_tmt  = 5;
  localparam int bit_trdy = 6;
  localparam int bit_rrdy = 7;
  localparam int bit_e    = 8;
  localparam int bit_eop  = 9;
  localparam int bit_sso  = 10;

  localparam ss_sel_t ss_reset_value = 4'b0001;

  // Engine timing
  localparam int sclk_half_period = 4;
  localparam int div_w            = $clog2(sclk_half_period);
  localparam int last_frame_state = 17;

  typedef logic [div_w-1:0] div_cnt_t;
  typedef logic [4:0]       frame_cnt_t;

  typedef enum logic [1:0] {
    eng_idle,
    eng_lead,
    eng_shift
  } engine_state_t;

endpackage

//--- common/spi_xfer_if.sv
// ------------------------------------------------
// Register block to shift engine link
// ------------------------------------------------
`timescale 1ns/1ps

interface spi_xfer_if;
  import spi_pkg::*;

  // Frame request from the register block
  logic      load;
  spi_data_t tx_byte;

  // Engine status and result
  logic      busy;
  logic      frame_active;
  logic      done;
  spi_data_t rx_byte;

  modport regs (
    output load,
    output tx_byte,
    input  busy,
    input  frame_active,
    input  done,
    input  rx_byte
  );

  modport engine (
    input  load,
    input  tx_byte,
    output busy,
    output frame_active,
    output done,
    output rx_byte
  );

endinterface

//--- spi_regs/spi_apb_regs.sv
// ------------------------------------------------
// SPI APB register file
// ------------------------------------------------
`timescale 1ns/1ps

module spi_apb_regs (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  spi_pkg::reg_addr_t paddr,
  input  spi_pkg::reg_data_t pwdata,
  output spi_pkg::reg_data_t prdata,
  output logic               irq,
  output spi_pkg::ss_sel_t   ss_n,
  spi_xfer_if.regs           xfer
);
  import spi_pkg::*;

  logic      wr_en;
  logic      rd_en;
  logic      data_wr;
  logic      data_rd;
  logic      status_wr;
  logic      control_wr;
  logic      ss_wr;
  logic      eop_wr;

  spi_data_t tx_hold;
  logic      tx_full;
  spi_data_t rx_data;
  spi_data_t eop_value;
  logic      rrdy;
  logic      roe;
  logic      toe;
  logic      eop;
  logic      tmt;
  logic      trdy;

  // Interrupt enables and force select
  logic      ie_roe;
  logic      ie_toe;
  logic      ie_trdy;
  logic      ie_rrdy;
  logic      ie_e;
  logic      ie_eop;
  logic      sso;

  ss_sel_t   ss_hold;
  ss_sel_t   ss_q;
  reg_data_t status_word;
  reg_data_t control_word;
  logic      irq_q;

  // Access phase strobes
  assign wr_en      = psel && penable && pwrite;
  assign rd_en      = psel && penable && !pwrite;
  assign data_wr    = wr_en && (paddr == addr_txdata);
  assign data_rd    = rd_en && (paddr == addr_rxdata);
  assign status_wr  = wr_en && (paddr == addr_status);
  assign control_wr = wr_en && (paddr == addr_control);
  assign ss_wr      = wr_en && (paddr == addr_slave_sel);
  assign eop_wr     = wr_en && (paddr == addr_eop_value);

  // Room in either the holding buffer or the engine
  assign trdy = !(xfer.busy && tx_full);
  assign tmt  = !xfer.busy && !tx_full;

  assign xfer.load    = tx_full && !xfer.busy;
  assign xfer.tx_byte = tx_hold;

  always_ff @(posedge clk)
  begin
    if (data_wr && trdy)
      tx_hold <= pwdata[spi_data_w-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (xfer.done)
      rx_data <= xfer.rx_byte;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      tx_full <= 1'b0;
      rrdy    <= 1'b0;
      roe     <= 1'b0;
      toe     <= 1'b0;
      eop     <= 1'b0;
    end
    else
    begin
      if (data_wr && trdy)
        tx_full <= 1'b1;
      else if (xfer.load)
        tx_full <= 1'b0;

      // Dropped write
      if (data_wr && !trdy)
        toe <= 1'b1;

      if (data_rd)
        rrdy <= 1'b0;

      if ((data_wr && (pwdata[spi_data_w-1:0] == eop_value)) ||
          (data_rd && (rx_data == eop_value)))
        eop <= 1'b1;

      // Any status write clears the sticky flags
      if (status_wr)
      begin
        rrdy <= 1'b0;
        roe  <= 1'b0;
        toe  <= 1'b0;
        eop  <= 1'b0;
      end

      // Frame completion overrides a same-cycle clear
      if (xfer.done)
      begin
        rrdy <= 1'b1;
        if (rrdy)
          roe <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ie_roe    <= 1'b0;
      ie_toe    <= 1'b0;
      ie_trdy   <= 1'b0;
      ie_rrdy   <= 1'b0;
      ie_e      <= 1'b0;
      ie_eop    <= 1'b0;
      sso       <= 1'b0;
      eop_value <= '0;
    end
    else
    begin
      if (control_wr)
      begin
        ie_roe  <= pwdata[bit_roe];
        ie_toe  <= pwdata[bit_toe];
        ie_trdy <= pwdata[bit_trdy];
        ie_rrdy <= pwdata[bit_rrdy];
        ie_e    <= pwdata[bit_e];
        ie_eop  <= pwdata[bit_eop];
        sso     <= pwdata[bit_sso];
      end
      if (eop_wr)
        eop_value <= pwdata[spi_data_w-1:0];
    end
  end

  // Holding copy moves to the active select at frame start or forced select
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ss_hold <= ss_reset_value;
      ss_q    <= ss_reset_value;
    end
    else
    begin
      if (ss_wr)
        ss_hold <= pwdata[ss_w-1:0];
      if (xfer.load || (control_wr && pwdata[bit_sso]))
        ss_q <= ss_hold;
    end
  end

  assign ss_n = (xfer.frame_active || sso) ? ~ss_q : '1;

  always_comb
  begin
    status_word           = '0;
    status_word[bit_roe]  = roe;
    status_word[bit_toe]  = toe;
    status_word[bit_tmt]  = tmt;
    status_word[bit_trdy] = trdy;
    status_word[bit_rrdy] = rrdy;
    status_word[bit_e]    = roe || toe;
    status_word[bit_eop]  = eop;
  end

  always_comb
  begin
    control_word           = '0;
    control_word[bit_roe]  = ie_roe;
    control_word[bit_toe]  = ie_toe;
    control_word[bit_trdy] = ie_trdy;
    control_word[bit_rrdy] = ie_rrdy;
    control_word[bit_e]    = ie_e;
    control_word[bit_eop]  = ie_eop;
    control_word[bit_sso]  = sso;
  end

  // Read mux, reserved words read as zero
  always_comb
  begin
    case (paddr)
      addr_rxdata:    prdata = reg_data_t'(rx_data);
      addr_status:    prdata = status_word;
      addr_control:   prdata = control_word;
      addr_slave_sel: prdata = reg_data_t'(ss_q);
      addr_eop_value: prdata = reg_data_t'(eop_value);
      default:        prdata = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      irq_q <= 1'b0;
    else
      irq_q <= (eop && ie_eop) || ((roe || toe) && ie_e) || (rrdy && ie_rrdy) ||
               (trdy && ie_trdy) || (toe && ie_toe) || (roe && ie_roe);
  end

  assign irq = irq_q;

endmodule

//--- spi_engine/spi_shift_engine.sv
// ------------------------------------------------
// SPI mode 0 shift engine
// ------------------------------------------------
`timescale 1ns/1ps

module spi_shift_engine (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       miso,
  output logic       sclk,
  output logic       mosi,
  spi_xfer_if.engine xfer
);
  import spi_pkg::*;

  engine_state_t state_q;
  frame_cnt_t    frame_cnt;
  div_cnt_t      div_cnt;
  logic          tick;
  logic          last_tick;
  logic          sclk_q;
  logic          miso_q;
  spi_data_t     shift_q;

  assign xfer.busy         = (state_q != eng_idle);
  assign xfer.frame_active = (state_q == eng_shift);

  // One tick per half SCLK period while a frame runs
  assign tick = xfer.busy && (div_cnt == div_cnt_t'(sclk_half_period - 1));

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      div_cnt <= '0;
    else if (!xfer.busy || tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign last_tick = tick && (state_q == eng_shift) &&
                     (frame_cnt == frame_cnt_t'(last_frame_state));

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q   <= eng_idle;
      frame_cnt <= '0;
      sclk_q    <= 1'b0;
      miso_q    <= 1'b0;
      shift_q   <= '0;
    end
    else
    begin
      case (state_q)
        eng_idle:
        begin
          if (xfer.load)
          begin
            state_q   <= eng_lead;
            frame_cnt <= '0;
            shift_q   <= xfer.tx_byte;
          end
        end
        // Select setup, SCLK stays low
        eng_lead:
        begin
          if (tick)
          begin
            state_q   <= eng_shift;
            frame_cnt <= frame_cnt_t'(1);
          end
        end
        eng_shift:
        begin
          if (last_tick)
            state_q <= eng_idle;
          else if (tick)
          begin
            sclk_q    <= ~sclk_q;
            frame_cnt <= frame_cnt + 1'b1;
            // Sample on the rising edge, shift on the falling one
            if (!sclk_q)
              miso_q <= miso;
            else
              shift_q <= {shift_q[spi_data_w-2:0], miso_q};
          end
        end
        default:
          state_q <= eng_idle;
      endcase
    end
  end

  assign xfer.done    = last_tick;
  assign xfer.rx_byte = shift_q;

  assign sclk = sclk_q;
  assign mosi = shift_q[spi_data_w-1];

endmodule

//--- design/spi_master_top.sv
// ------------------------------------------------
// SPI master with APB registers
// ------------------------------------------------
`timescale 1ns/1ps

module spi_master_top (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [spi_pkg::apb_addr_w-1:0] paddr,
  input  logic [spi_pkg::apb_data_w-1:0] pwdata,
  output logic [spi_pkg::apb_data_w-1:0] prdata,
  output logic                          pready,
  output logic                          irq,
  output logic                          sclk,
  output logic                          mosi,
  input  logic                          miso,
  output spi_pkg::ss_sel_t              ss_n
);
  import spi_pkg::*;

  reg_data_t reg_rdata;

  spi_xfer_if xfer_i ();

  // Word addressed registers, upper data half unused
  spi_apb_regs regs_i (
    .clk     (clk),
    .reset_n (reset_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr[apb_addr_w-1:2]),
    .pwdata  (pwdata[reg_data_w-1:0]),
    .prdata  (reg_rdata),
    .irq     (irq),
    .ss_n    (ss_n),
    .xfer    (xfer_i)
  );

  spi_shift_engine engine_i (
    .clk     (clk),
    .reset_n (reset_n),
    .miso    (miso),
    .sclk    (sclk),
    .mosi    (mosi),
    .xfer    (xfer_i)
  );

  assign prdata = {{(apb_data_w - reg_data_w){1'b0}}, reg_rdata};
  assign pready = 1'b1;

endmodule

//--- test/spi_master_props.sv
// ------------------------------------------------
// SPI master pin and interrupt checks
// ------------------------------------------------
`timescale 1ns/1ps

module spi_master_props (
  input logic                          clk,
  input logic                          reset_n,
  input logic                          psel,
  input logic                          penable,
  input logic                          pwrite,
  input logic [spi_pkg::apb_addr_w-1:0] paddr,
  input logic                          sclk,
  input spi_pkg::ss_sel_t              ss_n,
  input logic                          irq,
  input logic                          flags_set,
  input logic                          trdy_irq
);
  import spi_pkg::*;

  int   fail_count = 0;
  logic status_wr;

  assign status_wr = psel && penable && pwrite && (paddr[apb_addr_w-1:2] == addr_status);

  // No SCLK activity with every slave released
  sclk_idle_a: assert property (@(posedge clk) disable iff (!reset_n)
    (ss_n == '1) |-> !sclk)
  else
  begin
    fail_count++;
    $error("sclk high while all slave selects are released");
  end

  // One select pattern per frame
  ss_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
    (ss_n != '1) |-> ($past(ss_n) == '1) || $stable(ss_n))
  else
  begin
    fail_count++;
    $error("ss_n changed pattern without releasing first");
  end

  // irq register lags the flags by one cycle
  irq_clear_a: assert property (@(posedge clk) disable iff (!reset_n)
    $past(status_wr, 2) && !$past(flags_set) && !$past(trdy_irq) |-> !irq)
  else
  begin
    fail_count++;
    $error("irq still high after a status write cleared all flags");
  end

endmodule

bind spi_master_top spi_master_props props_i (
  .clk       (clk),
  .reset_n   (reset_n),
  .psel      (psel),
  .penable   (penable),
  .pwrite    (pwrite),
  .paddr     (paddr),
  .sclk      (sclk),
  .ss_n      (ss_n),
  .irq       (irq),
  .flags_set (regs_i.rrdy || regs_i.roe || regs_i.toe || regs_i.eop),
  .trdy_irq  (regs_i.trdy && regs_i.ie_trdy)
);

//--- test/spi_master_tb.sv
// ------------------------------------------------
// SPI master testbench
// ------------------------------------------------
`timescale 1ns/1ps

module spi_master_tb;
  import spi_pkg::*;

  localparam int frame_cycles    = 18 * sclk_half_period;
  localparam int watchdog_cycles = 16 + 6 * 8 * frame_cycles + 500;

  logic        clk = 1'b0;
  logic        reset_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        irq;
  logic        sclk;
  logic        mosi;
  logic        miso;
  ss_sel_t     ss_n;

  logic [31:0] rng = 32'h4a9d;
  spi_data_t   eop_model;
  logic        eop_flag;
  int          checks = 0;
  int          errors = 0;

  spi_master_top dut_i (.*);

  // MOSI looped back to MISO
  assign miso = mosi;

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic spi_data_t next_byte();
    rng = xorshift32(rng);
    return rng[7:0];
  endfunction

  // Expected status word, E is the OR of both overrun flags
  function automatic logic [31:0] status_value(input logic roe, input logic toe,
                                               input logic tmt, input logic trdy,
                                               input logic rrdy, input logic eop);
    logic [31:0] s;
    s           = '0;
    s[bit_roe]  = roe;
    s[bit_toe]  = toe;
    s[bit_tmt]  = tmt;
    s[bit_trdy] = trdy;
    s[bit_rrdy] = rrdy;
    s[bit_e]    = roe || toe;
    s[bit_eop]  = eop;
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h", name, expected, actual);
    end
  endtask

  task automatic apb_write(input reg_addr_t idx, input logic [31:0] data);
    @(negedge clk);
    psel   = 1'b1;
    pwrite = 1'b1;
    paddr  = {idx, 2'b00};
    pwdata = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Read data and pready sampled mid access cycle
  task automatic apb_read(input reg_addr_t idx, output logic [31:0] data);
    @(negedge clk);
    psel   = 1'b1;
    pwrite = 1'b0;
    paddr  = {idx, 2'b00};
    @(negedge clk);
    penable = 1'b1;
    data    = prdata;
    check_value("pready", pready, 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input reg_addr_t idx, input string name,
                            input logic [31:0] expected);
    logic [31:0] data;
    apb_read(idx, data);
    check_value(name, data, expected);
  endtask

  task automatic wait_status(input logic [31:0] mask, input string what);
    logic [31:0] s;
    int          polls;
    s = '0;
    for (polls = 0; polls < 2 * frame_cycles && (s & mask) == 0; polls++)
      apb_read(addr_status, s);
    if ((s & mask) == 0)
    begin
      errors++;
      $display("Status never showed %s while waiting for a frame", what);
    end
  endtask

  task automatic send_byte(input spi_data_t b);
    apb_write(addr_txdata, {24'h0, b});
    if (b == eop_model)
      eop_flag = 1'b1;
  endtask

  task automatic read_rx(input spi_data_t expected);
    read_check(addr_rxdata, "rxdata", {24'h0, expected});
    if (expected == eop_model)
      eop_flag = 1'b1;
  endtask

  task automatic clear_status();
    apb_write(addr_status, 32'h0);
    eop_flag = 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("Test %0d %s: %0d errors", num, name, errors - errs_before);
  endtask

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles with tests still running", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    spi_data_t b1;
    spi_data_t b2;
    spi_data_t b3;
    int        errs;
    int        n;
    int        total;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    reset_n   = 1'b0;
    eop_model = '0;
    eop_flag  = 1'b0;
    repeat (16) @(negedge clk);
    reset_n = 1'b1;

    errs = errors;
    read_check(addr_status, "status", status_value(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
    read_check(addr_control, "control", 32'h0);
    read_check(addr_slave_sel, "slave_sel", 32'h1);
    check_value("irq", irq, 32'h0);
    report_test(1, "reset values", errs);

    errs = errors;
    b1   = next_byte();
    send_byte(b1);
    wait_status(1 << bit_rrdy, "RRDY");
    read_rx(b1);
    read_check(addr_status, "status", status_value(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, eop_flag));
    report_test(2, "loopback transfer", errs);

    // Third write lands while both buffers are full
    errs = errors;
    b1   = next_byte();
    b2   = next_byte();
    b3   = next_byte();
    send_byte(b1);
    send_byte(b2);
    send_byte(b3);
    read_check(addr_status, "status", status_value(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, eop_flag));
    wait_status(1 << bit_rrdy, "RRDY");
    read_rx(b1);
    wait_status(1 << bit_rrdy, "RRDY");
    read_rx(b2);
    read_check(addr_status, "status", status_value(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, eop_flag));
    report_test(3, "double buffer and TOE", errs);

    errs = errors;
    b1   = next_byte();
    b2   = next_byte();
    send_byte(b1);
    wait_status(1 << bit_rrdy, "RRDY");
    send_byte(b2);
    wait_status(1 << bit_roe, "ROE");
    read_check(addr_status, "status", status_value(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, eop_flag));
    clear_status();
    read_check(addr_status, "status", status_value(1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
    read_rx(b2);
    report_test(4, "receive overrun", errs);

    errs = errors;
    clear_status();
    b1        = next_byte();
    eop_model = b1;
    apb_write(addr_eop_value, {24'h0, b1});
    read_check(addr_eop_value, "eop_value", {24'h0, b1});
    apb_write(addr_control, 1 << bit_eop);
    @(negedge clk);
    check_value("irq", irq, 32'h0);
    send_byte(b1);
    wait_status(1 << bit_rrdy, "RRDY");
    read_check(addr_status, "status", status_value(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, eop_flag));
    check_value("irq", irq, 32'h1);
    read_rx(b1);
    clear_status();
    @(negedge clk);
    check_value("irq", irq, 32'h0);
    report_test(5, "end of packet interrupt", errs);

    errs = errors;
    apb_write(addr_slave_sel, 32'h4);
    b1 = next_byte();
    send_byte(b1);
    for (n = 0; n < frame_cycles && ss_n == '1; n++)
      @(negedge clk);
    if (ss_n == '1)
    begin
      errors++;
      $display("Slave select never asserted during the frame");
    end
    check_value("ss_n", ss_n, ss_sel_t'(~ss_sel_t'(4'h4)));
    wait_status(1 << bit_rrdy, "RRDY");
    read_rx(b1);
    read_check(addr_slave_sel, "slave_sel", 32'h4);
    check_value("ss_n", ss_n, 32'hf);
    // Forced select holds the pattern while idle
    apb_write(addr_control, 1 << bit_sso);
    check_value("ss_n", ss_n, ss_sel_t'(~ss_sel_t'(4'h4)));
    read_check(addr_control, "control", 1 << bit_sso);
    apb_write(addr_control, 32'h0);
    check_value("ss_n", ss_n, 32'hf);
    report_test(6, "slave select", errs);

    total = errors + dut_i.props_i.fail_count;
    $display("Tests: 6, checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.props_i.fail_count);
    if (total == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- compile.f
common/spi_pkg.sv
common/spi_xfer_if.sv
spi_regs/spi_apb_regs.sv
spi_engine/spi_shift_engine.sv
design/spi_master_top.sv
test/spi_master_props.sv
test/spi_master_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = spi_master_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
